//--- rtl/uf_decoder_pkg.sv
package uf_decoder_pkg;

    // decoder stage encodings
    localparam int STAGE_WIDTH = 3;
    localparam logic [STAGE_WIDTH-1:0] STAGE_IDLE = 3'd0;
    localparam logic [STAGE_WIDTH-1:0] STAGE_MEASUREMENT_LOADING = 3'd1;
    localparam logic [STAGE_WIDTH-1:0] STAGE_SPREAD_CLUSTER = 3'd2;
    localparam logic [STAGE_WIDTH-1:0] STAGE_SYNC_IS_ODD_CLUSTER = 3'd3;
    localparam logic [STAGE_WIDTH-1:0] STAGE_GROW_BOUNDARY = 3'd4;
    localparam logic [STAGE_WIDTH-1:0] STAGE_RESULT_CALCULATING = 3'd5;

    // state commands from the hub
    localparam logic [1:0] CMD_ADVANCE = 2'b01;
    localparam logic [1:0] CMD_TO_SYNC = 2'b11;
    localparam logic [1:0] CMD_TO_GROW = 2'b10;
    localparam logic [1:0] CMD_FINISH = 2'b00;

    // array sizing
    localparam int PU_PER_SLICE = 8;
    localparam int SLICE_COUNT = 2;
    localparam int PU_COUNT = PU_PER_SLICE * SLICE_COUNT;
    localparam int SLICE_ID_WIDTH = $clog2(SLICE_COUNT);
    localparam int PU_INDEX_WIDTH = $clog2(PU_PER_SLICE);
    localparam int PU_ADDR_WIDTH = 4;
    localparam int ITERATION_COUNTER_WIDTH = 8;
    localparam int CYCLE_COUNTER_WIDTH = 32;
    // ten cycles per unit before spread/sync counts as stuck
    localparam int DEADLOCK_THRESHOLD = PU_COUNT * 10;

    // message kind tag, top bit of every hub word
    localparam logic KIND_STATUS = 1'b0;
    localparam logic KIND_ROOT = 1'b1;

    typedef struct packed {
        logic kind;
        logic spare;
        logic [SLICE_ID_WIDTH-1:0] slice_id;
        logic has_odd_clusters;
        logic [STAGE_WIDTH-1:0] stage;
    } status_msg_t;

    typedef struct packed {
        logic kind;
        logic [PU_ADDR_WIDTH-1:0] root_address;
        logic is_odd_cardinality_root;
        logic is_touching_boundary;
    } root_msg_t;

    typedef union packed {
        status_msg_t status;
        root_msg_t root;
    } hub_msg_t;

    // command that leaves the stage unchanged
    function automatic logic [1:0] neutral_cmd(input logic [STAGE_WIDTH-1:0] s);
        if (s == STAGE_SPREAD_CLUSTER || s == STAGE_SYNC_IS_ODD_CLUSTER) begin
            return 2'b01;
        end
        return 2'b00;
    endfunction

endpackage

//--- rtl/stage_controller.sv
`timescale 1ns/1ps

module stage_controller
    import uf_decoder_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [1:0] state_signal,
    output logic [STAGE_WIDTH-1:0] stage,
    output logic result_valid,
    output logic [ITERATION_COUNTER_WIDTH-1:0] iteration_counter,
    output logic [CYCLE_COUNTER_WIDTH-1:0] cycle_counter,
    output logic deadlock
);

    // cycles spent waiting in spread/sync since the last grow
    logic [CYCLE_COUNTER_WIDTH-1:0] cycles_in_stage;

    // deadlock watch
    always_ff @(posedge clk) begin
        if (reset) begin
            cycles_in_stage <= '0;
        end else if (stage == STAGE_MEASUREMENT_LOADING || stage == STAGE_IDLE ||
                     stage == STAGE_GROW_BOUNDARY) begin
            cycles_in_stage <= '0;
        end else if (stage == STAGE_SPREAD_CLUSTER || stage == STAGE_SYNC_IS_ODD_CLUSTER) begin
            cycles_in_stage <= cycles_in_stage + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            deadlock <= 1'b0;
        end else if (start) begin
            deadlock <= 1'b0;
        end else if (cycles_in_stage > DEADLOCK_THRESHOLD) begin
            deadlock <= 1'b1;
        end
    end

    // one iteration per sync -> grow hop
    always_ff @(posedge clk) begin
        if (reset) begin
            iteration_counter <= '0;
        end else if (stage == STAGE_MEASUREMENT_LOADING) begin
            iteration_counter <= '0;
        end else if (stage == STAGE_SYNC_IS_ODD_CLUSTER && state_signal == CMD_TO_GROW) begin
            iteration_counter <= iteration_counter + 1'b1;
        end
    end

    // loading counts as cycle one
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_counter <= '0;
        end else if (stage == STAGE_MEASUREMENT_LOADING) begin
            cycle_counter <= 1;
        end else if (!result_valid) begin
            cycle_counter <= cycle_counter + 1'b1;
        end
    end

    // stage machine, stepped only by hub commands
    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_IDLE;
            result_valid <= 1'b0;
        end else begin
            case (stage)
                STAGE_IDLE: begin
                    if (state_signal == CMD_ADVANCE) begin
                        stage <= STAGE_MEASUREMENT_LOADING;
                    end
                end
                STAGE_MEASUREMENT_LOADING: begin
                    // single cycle, syndrome comes straight from the ports
                    stage <= STAGE_SPREAD_CLUSTER;
                    result_valid <= 1'b0;
                end
                STAGE_SPREAD_CLUSTER: begin
                    if (state_signal == CMD_TO_SYNC) begin
                        stage <= STAGE_SYNC_IS_ODD_CLUSTER;
                    end else if (state_signal == CMD_FINISH) begin
                        stage <= STAGE_RESULT_CALCULATING;
                    end
                end
                STAGE_SYNC_IS_ODD_CLUSTER: begin
                    if (state_signal == CMD_TO_GROW) begin
                        stage <= STAGE_GROW_BOUNDARY;
                    end else if (state_signal == CMD_FINISH) begin
                        stage <= STAGE_RESULT_CALCULATING;
                    end
                end
                STAGE_GROW_BOUNDARY: begin
                    if (state_signal == CMD_ADVANCE) begin
                        stage <= STAGE_SPREAD_CLUSTER;
                    end
                end
                STAGE_RESULT_CALCULATING: begin
                    // hold here until the root stream has drained
                    if (state_signal == CMD_ADVANCE) begin
                        stage <= STAGE_IDLE;
                        result_valid <= 1'b1;
                    end
                end
                default: begin
                    stage <= STAGE_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/decoding_slice.sv
`timescale 1ns/1ps

module decoding_slice
    import uf_decoder_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic [SLICE_ID_WIDTH-1:0] slice_id,
    input  logic [STAGE_WIDTH-1:0] stage,
    input  logic [PU_PER_SLICE-1:0] syndrome,
    input  logic [PU_PER_SLICE-1:0] boundary,
    input  logic message_flying,
    output logic msg_valid,
    input  logic msg_ready,
    output hub_msg_t msg_data
);

    logic [PU_PER_SLICE-1:0] odd_flags;
    logic [PU_PER_SLICE-1:0] orig_syndrome;
    logic [PU_PER_SLICE-1:0] reach;
    logic [PU_PER_SLICE-1:0] grown_reach;
    logic [STAGE_WIDTH-1:0] prev_stage;
    logic posted;
    // one extra bit marks the end of the root scan
    logic [PU_INDEX_WIDTH:0] root_idx;
    logic [PU_INDEX_WIDTH-1:0] pu_idx;
    logic fresh;
    logic report_stage;
    logic slot_free;
    logic result_scan;
    logic root_end;
    logic post_status;
    logic post_root;
    hub_msg_t status_word;
    hub_msg_t root_word;

    assign fresh = stage != prev_stage;
    assign report_stage = stage == STAGE_SPREAD_CLUSTER || stage == STAGE_SYNC_IS_ODD_CLUSTER;
    assign slot_free = !msg_valid || msg_ready;
    assign pu_idx = root_idx[PU_INDEX_WIDTH-1:0];
    assign root_end = root_idx[PU_INDEX_WIDTH];
    // reach spreads one unit left and right per grow
    assign grown_reach = reach | (reach << 1) | (reach >> 1);

    assign result_scan = stage == STAGE_RESULT_CALCULATING && !fresh && !posted && slot_free;
    assign post_status = (report_stage && (fresh || !posted) && slot_free && !message_flying) ||
                         (result_scan && root_end);
    assign post_root = result_scan && !root_end && orig_syndrome[pu_idx];

    // both views of the hub word
    always_comb begin
        status_word.status.kind = KIND_STATUS;
        status_word.status.spare = 1'b0;
        status_word.status.slice_id = slice_id;
        status_word.status.has_odd_clusters = |odd_flags;
        status_word.status.stage = stage;
        root_word.root.kind = KIND_ROOT;
        root_word.root.root_address = {slice_id, pu_idx};
        root_word.root.is_odd_cardinality_root = odd_flags[pu_idx];
        root_word.root.is_touching_boundary = reach[pu_idx];
    end

    // cluster state
    always_ff @(posedge clk) begin
        if (stage == STAGE_MEASUREMENT_LOADING) begin
            odd_flags <= syndrome;
            orig_syndrome <= syndrome;
            reach <= boundary;
        end else if (stage == STAGE_GROW_BOUNDARY && fresh) begin
            // odd units inside the new reach are absorbed
            reach <= grown_reach;
            odd_flags <= odd_flags & ~grown_reach;
        end
    end

    always_ff @(posedge clk) begin
        if (post_status) begin
            msg_data <= status_word;
        end else if (post_root) begin
            msg_data <= root_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_stage <= STAGE_IDLE;
            msg_valid <= 1'b0;
            posted <= 1'b0;
            root_idx <= '0;
        end else begin
            prev_stage <= stage;
            if (msg_valid && msg_ready) begin
                msg_valid <= 1'b0;
            end
            // new stage visit, rearm the report
            if (fresh) begin
                posted <= 1'b0;
                root_idx <= '0;
            end
            if (post_status || post_root) begin
                msg_valid <= 1'b1;
            end
            if (post_status) begin
                posted <= 1'b1;
            end
            if (result_scan && !root_end) begin
                root_idx <= root_idx + 1'b1;
            end
        end
    end

endmodule

//--- rtl/hub_arbiter.sv
`timescale 1ns/1ps

module hub_arbiter
    import uf_decoder_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic [1:0] req_valid,
    input  hub_msg_t req_data0,
    input  hub_msg_t req_data1,
    output logic [1:0] req_ready,
    output logic hub_valid,
    output hub_msg_t hub_data,
    input  logic hub_ready
);

    logic last_grant;
    // grant is pinned while a word waits for ready
    logic stalled;
    logic grant;

    // contention goes to the slice not served last
    assign grant = stalled ? last_grant : (&req_valid ? !last_grant : req_valid[1]);

    assign hub_valid = req_valid[grant];
    assign hub_data = grant ? req_data1 : req_data0;
    assign req_ready = {hub_ready && grant, hub_ready && !grant};

    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant <= 1'b1;
            stalled <= 1'b0;
        end else if (hub_valid) begin
            last_grant <= grant;
            stalled <= !hub_ready;
        end
    end

endmodule

//--- rtl/hub_sequencer.sv
`timescale 1ns/1ps

module hub_sequencer
    import uf_decoder_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [STAGE_WIDTH-1:0] stage,
    input  logic hub_valid,
    input  hub_msg_t hub_data,
    output logic hub_ready,
    output logic [1:0] state_signal,
    output logic root_valid,
    output hub_msg_t root_data,
    input  logic root_ready
);

    // per-slice report bookkeeping for the current stage
    logic [SLICE_COUNT-1:0] received;
    logic [SLICE_COUNT-1:0] odd_seen;
    logic grow_waited;
    logic is_root;
    logic accept;
    logic issue;

    assign is_root = hub_data.root.kind == KIND_ROOT;
    // roots stall on the output register, status always drains
    assign hub_ready = is_root ? (!root_valid || root_ready) : 1'b1;
    assign accept = hub_valid && hub_ready;

    // loading and unknown stages keep the neutral command
    always_comb begin
        state_signal = neutral_cmd(stage);
        case (stage)
            STAGE_IDLE: begin
                if (start) begin
                    state_signal = CMD_ADVANCE;
                end
            end
            STAGE_SPREAD_CLUSTER: begin
                if (&received) begin
                    state_signal = |odd_seen ? CMD_TO_SYNC : CMD_FINISH;
                end
            end
            STAGE_SYNC_IS_ODD_CLUSTER: begin
                if (&received) begin
                    state_signal = |odd_seen ? CMD_TO_GROW : CMD_FINISH;
                end
            end
            STAGE_GROW_BOUNDARY: begin
                // slices dilate in the first grow cycle
                if (grow_waited) begin
                    state_signal = CMD_ADVANCE;
                end
            end
            STAGE_RESULT_CALCULATING: begin
                // both end reports in and last root gone
                if (&received && !root_valid) begin
                    state_signal = CMD_ADVANCE;
                end
            end
        endcase
    end

    // any non-neutral command moves the stage on the next edge
    assign issue = state_signal != neutral_cmd(stage);

    always_ff @(posedge clk) begin
        if (reset) begin
            received <= '0;
            odd_seen <= '0;
            grow_waited <= 1'b0;
            root_valid <= 1'b0;
        end else begin
            if (root_valid && root_ready) begin
                root_valid <= 1'b0;
            end
            if (accept && is_root) begin
                root_valid <= 1'b1;
            end
            // reports tagged with an older stage are dropped
            if (accept && !is_root && hub_data.status.stage == stage) begin
                received[hub_data.status.slice_id] <= 1'b1;
                odd_seen[hub_data.status.slice_id] <= hub_data.status.has_odd_clusters;
            end
            if (stage == STAGE_GROW_BOUNDARY) begin
                grow_waited <= 1'b1;
            end
            if (issue) begin
                received <= '0;
                odd_seen <= '0;
                grow_waited <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_root) begin
            root_data <= hub_data;
        end
    end

endmodule

//--- rtl/uf_decoder_top.sv
`timescale 1ns/1ps

module uf_decoder_top
    import uf_decoder_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic [PU_COUNT-1:0] syndrome,
    input  logic [PU_COUNT-1:0] boundary,
    input  logic [SLICE_COUNT-1:0] message_flying,
    input  logic root_ready,
    output logic root_valid,
    output hub_msg_t root_data,
    output logic [STAGE_WIDTH-1:0] stage,
    output logic result_valid,
    output logic [ITERATION_COUNTER_WIDTH-1:0] iteration_counter,
    output logic [CYCLE_COUNTER_WIDTH-1:0] cycle_counter,
    output logic deadlock
);

    logic [1:0] state_signal;
    logic [SLICE_COUNT-1:0] slice_msg_valid;
    logic [SLICE_COUNT-1:0] slice_msg_ready;
    hub_msg_t slice_msg_data0;
    hub_msg_t slice_msg_data1;
    logic hub_valid;
    logic hub_ready;
    hub_msg_t hub_data;

    stage_controller u_stage_controller (
        .clk(clk),
        .reset(reset),
        .start(start),
        .state_signal(state_signal),
        .stage(stage),
        .result_valid(result_valid),
        .iteration_counter(iteration_counter),
        .cycle_counter(cycle_counter),
        .deadlock(deadlock)
    );

    // slice 0 holds units 0..7, slice 1 units 8..15
    decoding_slice u_slice0 (
        .clk(clk),
        .reset(reset),
        .slice_id(1'b0),
        .stage(stage),
        .syndrome(syndrome[PU_PER_SLICE-1:0]),
        .boundary(boundary[PU_PER_SLICE-1:0]),
        .message_flying(message_flying[0]),
        .msg_valid(slice_msg_valid[0]),
        .msg_ready(slice_msg_ready[0]),
        .msg_data(slice_msg_data0)
    );

    decoding_slice u_slice1 (
        .clk(clk),
        .reset(reset),
        .slice_id(1'b1),
        .stage(stage),
        .syndrome(syndrome[PU_COUNT-1:PU_PER_SLICE]),
        .boundary(boundary[PU_COUNT-1:PU_PER_SLICE]),
        .message_flying(message_flying[1]),
        .msg_valid(slice_msg_valid[1]),
        .msg_ready(slice_msg_ready[1]),
        .msg_data(slice_msg_data1)
    );

    hub_arbiter u_hub_arbiter (
        .clk(clk),
        .reset(reset),
        .req_valid(slice_msg_valid),
        .req_data0(slice_msg_data0),
        .req_data1(slice_msg_data1),
        .req_ready(slice_msg_ready),
        .hub_valid(hub_valid),
        .hub_data(hub_data),
        .hub_ready(hub_ready)
    );

    hub_sequencer u_hub_sequencer (
        .clk(clk),
        .reset(reset),
        .start(start),
        .stage(stage),
        .hub_valid(hub_valid),
        .hub_data(hub_data),
        .hub_ready(hub_ready),
        .state_signal(state_signal),
        .root_valid(root_valid),
        .root_data(root_data),
        .root_ready(root_ready)
    );

endmodule

//--- sim/uf_checker.sv
`timescale 1ns/1ps

module uf_checker
    import uf_decoder_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic start,
    input logic [STAGE_WIDTH-1:0] stage,
    input logic result_valid,
    input logic [ITERATION_COUNTER_WIDTH-1:0] iteration_counter,
    input logic [CYCLE_COUNTER_WIDTH-1:0] cycle_counter,
    input logic deadlock,
    input logic root_valid,
    input hub_msg_t root_data,
    input logic root_ready
);

    string test_name = "none";
    int error_count = 0;
    int exp_iterations = 0;
    logic deadlock_expected = 1'b0;
    // expected root records, one list per slice
    hub_msg_t exp_roots0[$];
    hub_msg_t exp_roots1[$];
    int active_cycles = 0;
    int loading_cycles = 0;
    int spread_cycles = 0;
    // previous sampled values
    logic reset_q = 1'b0;
    logic result_valid_q = 1'b0;
    logic deadlock_q = 1'b0;
    logic start_q = 1'b0;
    // record waiting on root_ready in the last cycle
    logic held = 1'b0;
    hub_msg_t held_data;

    task automatic begin_test(input string name, input logic expect_deadlock);
        test_name = name;
        deadlock_expected = expect_deadlock;
        exp_iterations = 0;
        exp_roots0.delete();
        exp_roots1.delete();
        active_cycles = 0;
        loading_cycles = 0;
    endtask

    task automatic set_iterations(input int n);
        exp_iterations = n;
    endtask

    // top address bit selects the slice
    task automatic push_root(input hub_msg_t word);
        if (word.root.root_address[PU_ADDR_WIDTH-1]) begin
            exp_roots1.push_back(word);
        end else begin
            exp_roots0.push_back(word);
        end
    endtask

    task automatic check_equal(input string what, input longint expected, input longint actual);
        if (expected != actual) begin
            error_count++;
            $display("CHECK FAILED %s: %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic note_failure(input string msg);
        error_count++;
        $display("ERROR %s: %s", test_name, msg);
    endtask

    task automatic take_root(input hub_msg_t actual);
        hub_msg_t expected;
        logic found;
        found = 1'b0;
        if (actual.root.root_address[PU_ADDR_WIDTH-1]) begin
            if (exp_roots1.size() > 0) begin
                expected = exp_roots1.pop_front();
                found = 1'b1;
            end
        end else if (exp_roots0.size() > 0) begin
            expected = exp_roots0.pop_front();
            found = 1'b1;
        end
        if (!found) begin
            note_failure($sformatf("root record 0x%0h was not expected", actual));
        end else begin
            check_equal("root record", expected, actual);
        end
    endtask

    always @(posedge clk) begin : watch_ports
        if (reset_q && !reset) begin
            check_equal("stage after reset", STAGE_IDLE, stage);
            check_equal("result_valid after reset", 0, result_valid);
            check_equal("deadlock after reset", 0, deadlock);
            check_equal("root_valid after reset", 0, root_valid);
        end
        if (!reset) begin
            // cycles from loading up to the result_valid edge
            if (stage != STAGE_IDLE) begin
                active_cycles++;
            end
            if (stage == STAGE_MEASUREMENT_LOADING) begin
                loading_cycles++;
            end
            if (stage == STAGE_SPREAD_CLUSTER) begin
                spread_cycles++;
            end else begin
                spread_cycles = 0;
            end
            // stalled record must still be there, unchanged
            if (held) begin
                if (!root_valid) begin
                    note_failure("root record withdrawn while root_ready was low");
                end else begin
                    check_equal("stalled root record", held_data, root_data);
                end
            end
            if (root_valid && root_ready) begin
                take_root(root_data);
            end
            held = root_valid && !root_ready;
            held_data = root_data;
            if (start_q) begin
                check_equal("deadlock after start", 0, deadlock);
            end
            if (deadlock && !deadlock_q) begin
                if (!deadlock_expected) begin
                    check_equal("deadlock", 0, deadlock);
                end else if (spread_cycles <= DEADLOCK_THRESHOLD) begin
                    note_failure($sformatf("deadlock set after only %0d spread cycles",
                                           spread_cycles));
                end
            end
            // end of a decode run
            if (result_valid && !result_valid_q) begin
                check_equal("iteration_counter", exp_iterations, iteration_counter);
                check_equal("cycle_counter", active_cycles, cycle_counter);
                check_equal("loading stage cycles", 1, loading_cycles);
                if (exp_roots0.size() + exp_roots1.size() != 0) begin
                    note_failure($sformatf("%0d root records never arrived",
                                           exp_roots0.size() + exp_roots1.size()));
                end
            end
        end
        reset_q = reset;
        result_valid_q = result_valid;
        deadlock_q = deadlock;
        start_q = start;
    end

endmodule

//--- sim/tb_uf_decoder.sv
`timescale 1ns/1ps

module tb_uf_decoder
    import uf_decoder_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 5;
    localparam int ROUNDS = 8;
    // generous bound for one decode run, stalls included
    localparam int RUN_CYCLE_BUDGET = 400;
    localparam int WATCHDOG_CYCLES = (2 * ROUNDS + 4) * RUN_CYCLE_BUDGET + 2 * DEADLOCK_THRESHOLD;

    logic clk;
    logic reset;
    logic start;
    logic [PU_COUNT-1:0] syndrome;
    logic [PU_COUNT-1:0] boundary;
    logic [SLICE_COUNT-1:0] message_flying;
    logic root_ready;
    logic root_valid;
    hub_msg_t root_data;
    logic [STAGE_WIDTH-1:0] stage;
    logic result_valid;
    logic [ITERATION_COUNTER_WIDTH-1:0] iteration_counter;
    logic [CYCLE_COUNTER_WIDTH-1:0] cycle_counter;
    logic deadlock;

    logic [31:0] rng;
    logic stall_mode;
    int tests_passed;
    int tests_failed;
    int errors_before;
    string current_test;

    uf_decoder_top DUT (
        .clk(clk),
        .reset(reset),
        .start(start),
        .syndrome(syndrome),
        .boundary(boundary),
        .message_flying(message_flying),
        .root_ready(root_ready),
        .root_valid(root_valid),
        .root_data(root_data),
        .stage(stage),
        .result_valid(result_valid),
        .iteration_counter(iteration_counter),
        .cycle_counter(cycle_counter),
        .deadlock(deadlock)
    );

    uf_checker u_uf_checker (
        .clk(clk),
        .reset(reset),
        .start(start),
        .stage(stage),
        .result_valid(result_valid),
        .iteration_counter(iteration_counter),
        .cycle_counter(cycle_counter),
        .deadlock(deadlock),
        .root_valid(root_valid),
        .root_data(root_data),
        .root_ready(root_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // one clock, with random back-pressure when stalling
    task automatic step_cycle();
        @(posedge clk);
        if (stall_mode) begin
            rng = xorshift32(rng);
            root_ready <= rng[0];
        end else begin
            root_ready <= 1'b1;
        end
    endtask

    task automatic open_test(input string name, input logic expect_deadlock);
        current_test = name;
        errors_before = u_uf_checker.error_count;
        u_uf_checker.begin_test(name, expect_deadlock);
    endtask

    task automatic close_test();
        int errs;
        errs = u_uf_checker.error_count - errors_before;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: ok", current_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d failed checks", current_test, errs);
        end
    endtask

    task automatic draw_inputs(output logic [PU_COUNT-1:0] syn, output logic [PU_COUNT-1:0] bnd);
        logic [31:0] mask;
        rng = xorshift32(rng);
        syn = rng[15:0];
        mask = rng;
        rng = xorshift32(rng);
        // sparse boundary, so clusters take several grow steps
        bnd = rng[31:16] & mask[31:16];
        // each slice needs a boundary unit or its clusters never close
        bnd[rng[2:0]] = 1'b1;
        bnd[PU_PER_SLICE + rng[5:3]] = 1'b1;
    endtask

    // reference model: 1-d reach grows one unit each way per step
    task automatic predict_run(input logic [PU_COUNT-1:0] syn, input logic [PU_COUNT-1:0] bnd);
        logic [PU_PER_SLICE-1:0] odd [SLICE_COUNT];
        logic [PU_PER_SLICE-1:0] reach [SLICE_COUNT];
        logic [PU_PER_SLICE-1:0] grown;
        hub_msg_t word;
        int steps;
        int s;
        int u;
        steps = 0;
        for (s = 0; s < SLICE_COUNT; s++) begin
            odd[s] = syn[s * PU_PER_SLICE +: PU_PER_SLICE];
            reach[s] = bnd[s * PU_PER_SLICE +: PU_PER_SLICE];
        end
        while (((odd[0] | odd[1]) != 0) && steps < 2 * PU_PER_SLICE) begin
            for (s = 0; s < SLICE_COUNT; s++) begin
                grown = reach[s] | (reach[s] << 1) | (reach[s] >> 1);
                reach[s] = grown;
                odd[s] = odd[s] & ~grown;
            end
            steps++;
        end
        u_uf_checker.set_iterations(steps);
        // one record per originally odd unit, ascending
        for (s = 0; s < SLICE_COUNT; s++) begin
            for (u = 0; u < PU_PER_SLICE; u++) begin
                if (syn[s * PU_PER_SLICE + u]) begin
                    word.root.kind = KIND_ROOT;
                    word.root.root_address = s * PU_PER_SLICE + u;
                    word.root.is_odd_cardinality_root = odd[s][u];
                    word.root.is_touching_boundary = reach[s][u];
                    u_uf_checker.push_root(word);
                end
            end
        end
    endtask

    task automatic run_decode(input string name, input logic [PU_COUNT-1:0] syn,
                              input logic [PU_COUNT-1:0] bnd, input logic hold_flying);
        open_test(name, hold_flying);
        predict_run(syn, bnd);
        step_cycle();
        syndrome <= syn;
        boundary <= bnd;
        message_flying <= {1'b0, hold_flying};
        start <= 1'b1;
        step_cycle();
        start <= 1'b0;
        do step_cycle(); while (stage != STAGE_MEASUREMENT_LOADING);
        // slice 0 held back in spread until the controller flags deadlock
        if (hold_flying) begin
            do step_cycle(); while (deadlock !== 1'b1);
            message_flying <= '0;
        end
        do step_cycle(); while (result_valid !== 1'b1);
        // checker compares on that edge
        step_cycle();
        close_test();
    endtask

    initial begin : main_sequence
        logic [PU_COUNT-1:0] syn;
        logic [PU_COUNT-1:0] bnd;
        int i;
        rng = 32'hf615;
        reset = 1'b1;
        start = 1'b0;
        syndrome = '0;
        boundary = '0;
        message_flying = '0;
        root_ready = 1'b1;
        stall_mode = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        open_test("after_reset", 1'b0);
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        close_test();
        draw_inputs(syn, bnd);
        run_decode("zero_syndrome", '0, bnd, 1'b0);
        for (i = 0; i < ROUNDS; i++) begin
            draw_inputs(syn, bnd);
            run_decode($sformatf("random_%0d", i), syn, bnd, 1'b0);
        end
        stall_mode = 1'b1;
        for (i = 0; i < ROUNDS; i++) begin
            draw_inputs(syn, bnd);
            run_decode($sformatf("stalled_%0d", i), syn, bnd, 1'b0);
        end
        stall_mode = 1'b0;
        draw_inputs(syn, bnd);
        run_decode("deadlock_set", syn, bnd, 1'b1);
        draw_inputs(syn, bnd);
        run_decode("deadlock_clear", syn, bnd, 1'b0);
        $display("summary: %0d tests, %0d passed, %0d failed, %0d failed checks",
                 tests_passed + tests_failed, tests_passed, tests_failed,
                 u_uf_checker.error_count);
        if (tests_failed == 0 && u_uf_checker.error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: %s still running after %0d cycles, stage %0d",
                 current_test, WATCHDOG_CYCLES, stage);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- list.f
rtl/uf_decoder_pkg.sv
rtl/stage_controller.sv
rtl/decoding_slice.sv
rtl/hub_arbiter.sv
rtl/hub_sequencer.sv
rtl/uf_decoder_top.sv
sim/uf_checker.sv
sim/tb_uf_decoder.sv
